// File: verilog/pipe_pkg.sv
package pipe_pkg;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // how execute picks the ALU function
    typedef enum logic [1:0] {
        OPC_R    = 2'd0, // funct3 plus funct7 bit 5
        OPC_I    = 2'd1, // funct3 only
        OPC_ADDR = 2'd2, // plain add for addresses
        OPC_PASS = 2'd3  // immediate straight through
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne; // taken on not-equal when branch is set
        logic      alu_src;   // b operand from imm and marks JALR among jumps
        op_class_e op_class;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic        jump;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc_plus;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [9:0]  funct; // {funct7, funct3}
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd_addr;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd_addr;
    } ex_mem_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic [31:0]     inst_i,
    input  logic [31:0]     pc_i,
    output pipe_pkg::ctrl_t ctrl_o,
    output logic            jump_o,
    output logic [31:0]     imm_o,
    output logic [9:0]      funct_o,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    output logic [4:0]      rd_addr_o,
    output logic [31:0]     pc_plus_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i_fmt;
    logic [31:0] imm_s_fmt;
    logic [31:0] imm_b_fmt;
    logic [31:0] imm_j_fmt;
    logic [31:0] imm_u_fmt;
    logic        use_rs1;
    logic        use_rs2;
    logic        use_rd;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};
    assign imm_u_fmt = {inst_i[31:12], 12'b0};

    always_comb begin
        ctrl_o  = '0;
        jump_o  = 1'b0;
        imm_o   = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opcode)
            pipe_pkg::OP_R: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.op_class  = pipe_pkg::OPC_R;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                use_rd           = 1'b1;
            end
            pipe_pkg::OP_I: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.op_class  = pipe_pkg::OPC_I;
                imm_o            = imm_i_fmt;
                use_rs1          = 1'b1;
                use_rd           = 1'b1;
            end
            pipe_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin // LW only
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.alu_src   = 1'b1;
                    ctrl_o.op_class  = pipe_pkg::OPC_ADDR;
                    imm_o            = imm_i_fmt;
                    use_rs1          = 1'b1;
                    use_rd           = 1'b1;
                end
            end
            pipe_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin // SW only
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.alu_src   = 1'b1;
                    ctrl_o.op_class  = pipe_pkg::OPC_ADDR;
                    imm_o            = imm_s_fmt;
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                end
            end
            pipe_pkg::OP_BRANCH: begin
                if (funct3[2:1] == 2'b00) begin // BEQ, BNE
                    ctrl_o.branch    = 1'b1;
                    ctrl_o.branch_ne = funct3[0];
                    ctrl_o.op_class  = pipe_pkg::OPC_ADDR;
                    imm_o            = imm_b_fmt;
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                end
            end
            pipe_pkg::OP_JAL: begin
                ctrl_o.reg_write = 1'b1;
                jump_o           = 1'b1;
                imm_o            = imm_j_fmt;
                use_rd           = 1'b1;
            end
            pipe_pkg::OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.alu_src   = 1'b1;
                    ctrl_o.op_class  = pipe_pkg::OPC_ADDR;
                    jump_o           = 1'b1;
                    imm_o            = imm_i_fmt;
                    use_rs1          = 1'b1;
                    use_rd           = 1'b1;
                end
            end
            pipe_pkg::OP_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.op_class  = pipe_pkg::OPC_PASS;
                imm_o            = imm_u_fmt;
                use_rd           = 1'b1;
            end
            default: ; // unsupported words leave a bubble
        endcase
    end

    // unused fields read as x0 so the hazard check stays quiet
    assign rs1_addr_o = use_rs1 ? inst_i[19:15] : 5'd0;
    assign rs2_addr_o = use_rs2 ? inst_i[24:20] : 5'd0;
    assign rd_addr_o  = use_rd ? inst_i[11:7] : 5'd0;
    assign funct_o    = {inst_i[31:25], funct3};
    assign pc_plus_o  = pc_i + 32'd4;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic [4:0]    rs1_addr_i,
    input  logic [4:0]    rs2_addr_i,
    input  pipe_pkg::wb_t wb_i,
    output logic [31:0]   rs1_data_o,
    output logic [31:0]   rs2_data_o
);

    logic [31:0] regs [1:31]; // x0 has no storage
    logic        wr_en;

    assign wr_en = wb_i.we && (wb_i.rd != 5'd0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle writeback wins over the stored value
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 :
                        (wr_en && wb_i.rd == rs1_addr_i) ? wb_i.data :
                        regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 :
                        (wr_en && wb_i.rd == rs2_addr_i) ? wb_i.data :
                        regs[rs2_addr_i];

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  pipe_pkg::id_ex_t ex_entry_i,
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    output logic             fetch_stall_o,
    output logic             bubble_o
);

    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    assign load_in_ex = ex_entry_i.ctrl.mem_read && (ex_entry_i.rd_addr != 5'd0);
    assign rs1_hit    = (ex_entry_i.rd_addr == rs1_addr_i);
    assign rs2_hit    = (ex_entry_i.rd_addr == rs2_addr_i);
    assign load_use   = load_in_ex && (rs1_hit || rs2_hit);

    // IF/ID holds and the ID/EX slot gets a bubble in the same cycle
    assign fetch_stall_o = load_use;
    assign bubble_o      = load_use;

endmodule

// File: verilog/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            q_o <= '0;
        end else if (hold_i) begin
            q_o <= q_o;
        end else if (flush_i) begin
            q_o <= '0; // all-zero entry is a bubble
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  pipe_pkg::id_ex_t  entry_i,
    input  pipe_pkg::ex_mem_t ex_mem_i,
    input  pipe_pkg::wb_t     wb_i,
    output pipe_pkg::ex_mem_t result_o,
    output logic              redirect_o,
    output logic [31:0]       redirect_pc_o
);

    logic [31:0]       op_a;
    logic [31:0]       op_rs2;
    logic [31:0]       op_b;
    logic [31:0]       alu_out;
    logic [31:0]       jalr_sum;
    logic              equal;
    logic              taken;
    pipe_pkg::alu_op_e alu_op;

    // loads skip the EX/MEM path and come back via wb_i
    function automatic logic [31:0] forward(
        input logic [4:0]        addr,
        input logic [31:0]       reg_val,
        input pipe_pkg::ex_mem_t mem,
        input pipe_pkg::wb_t     wb
    );
        if (mem.reg_write && !mem.mem_read && mem.rd_addr != 5'd0 && mem.rd_addr == addr) begin
            return mem.result;
        end else if (wb.we && wb.rd != 5'd0 && wb.rd == addr) begin
            return wb.data;
        end
        return reg_val;
    endfunction

    assign op_a   = forward(entry_i.rs1_addr, entry_i.rs1_data, ex_mem_i, wb_i);
    assign op_rs2 = forward(entry_i.rs2_addr, entry_i.rs2_data, ex_mem_i, wb_i);
    assign op_b   = entry_i.ctrl.alu_src ? entry_i.imm : op_rs2;

    always_comb begin
        alu_op = pipe_pkg::ALU_ADD;
        case (entry_i.ctrl.op_class)
            pipe_pkg::OPC_R, pipe_pkg::OPC_I: begin
                case (entry_i.funct[2:0])
                    3'b000: begin
                        // only R-type uses funct7 for SUB
                        if (entry_i.ctrl.op_class == pipe_pkg::OPC_R && entry_i.funct[8]) begin
                            alu_op = pipe_pkg::ALU_SUB;
                        end
                    end
                    3'b111: alu_op = pipe_pkg::ALU_AND;
                    3'b110: alu_op = pipe_pkg::ALU_OR;
                    3'b100: alu_op = pipe_pkg::ALU_XOR;
                    3'b010: alu_op = pipe_pkg::ALU_SLT;
                    3'b001: alu_op = pipe_pkg::ALU_SLL;
                    3'b101: alu_op = pipe_pkg::ALU_SRL;
                    default: alu_op = pipe_pkg::ALU_ADD;
                endcase
            end
            pipe_pkg::OPC_PASS: alu_op = pipe_pkg::ALU_PASS_B;
            default: alu_op = pipe_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            pipe_pkg::ALU_SUB:    alu_out = op_a - op_b;
            pipe_pkg::ALU_AND:    alu_out = op_a & op_b;
            pipe_pkg::ALU_OR:     alu_out = op_a | op_b;
            pipe_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            pipe_pkg::ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            pipe_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
            pipe_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
            pipe_pkg::ALU_PASS_B: alu_out = op_b;
            default:              alu_out = op_a + op_b;
        endcase
    end

    assign equal    = (op_a == op_rs2);
    assign taken    = entry_i.ctrl.branch && (equal ^ entry_i.ctrl.branch_ne);
    assign jalr_sum = op_a + entry_i.imm;

    assign redirect_o    = taken || entry_i.jump;
    // alu_src on a jump means JALR
    assign redirect_pc_o = (entry_i.jump && entry_i.ctrl.alu_src) ? {jalr_sum[31:1], 1'b0} :
                           entry_i.pc + entry_i.imm;

    assign result_o.reg_write  = entry_i.ctrl.reg_write;
    assign result_o.mem_read   = entry_i.ctrl.mem_read;
    assign result_o.mem_write  = entry_i.ctrl.mem_write;
    assign result_o.result     = entry_i.jump ? entry_i.pc_plus : alu_out; // link value
    assign result_o.store_data = op_rs2;
    assign result_o.rd_addr    = entry_i.rd_addr;

endmodule

// File: verilog/decode_execute_top.sv
`timescale 1ns/10ps

module decode_execute_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [31:0]       inst_i,
    input  logic [31:0]       pc_i,
    input  pipe_pkg::wb_t     wb_i,
    input  logic              mem_stall_i,
    output logic              fetch_stall_o,
    output logic              redirect_o,
    output logic [31:0]       redirect_pc_o,
    output pipe_pkg::ex_mem_t ex_mem_o
);

    pipe_pkg::id_ex_t  id_entry;
    pipe_pkg::id_ex_t  ex_entry;
    pipe_pkg::ex_mem_t ex_result;
    logic              bubble;
    logic              id_ex_flush;

    inst_decoder decoder0 (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .ctrl_o     (id_entry.ctrl),
        .jump_o     (id_entry.jump),
        .imm_o      (id_entry.imm),
        .funct_o    (id_entry.funct),
        .rs1_addr_o (id_entry.rs1_addr),
        .rs2_addr_o (id_entry.rs2_addr),
        .rd_addr_o  (id_entry.rd_addr),
        .pc_plus_o  (id_entry.pc_plus)
    );

    assign id_entry.pc = pc_i;

    reg_file regs0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (id_entry.rs1_addr),
        .rs2_addr_i (id_entry.rs2_addr),
        .wb_i       (wb_i),
        .rs1_data_o (id_entry.rs1_data),
        .rs2_data_o (id_entry.rs2_data)
    );

    hazard_unit hazard0 (
        .ex_entry_i    (ex_entry),
        .rs1_addr_i    (id_entry.rs1_addr),
        .rs2_addr_i    (id_entry.rs2_addr),
        .fetch_stall_o (fetch_stall_o),
        .bubble_o      (bubble)
    );

    // kill the decode slot on load-use or on a redirect from execute
    assign id_ex_flush = bubble || redirect_o;

    stage_reg #(
        .payload_t (pipe_pkg::id_ex_t)
    ) id_ex_reg0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .hold_i  (mem_stall_i),
        .flush_i (id_ex_flush),
        .d_i     (id_entry),
        .q_o     (ex_entry)
    );

    exec_stage exec0 (
        .entry_i       (ex_entry),
        .ex_mem_i      (ex_mem_o),
        .wb_i          (wb_i),
        .result_o      (ex_result),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    stage_reg #(
        .payload_t (pipe_pkg::ex_mem_t)
    ) ex_mem_reg0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .hold_i  (mem_stall_i),
        .flush_i (1'b0),
        .d_i     (ex_result),
        .q_o     (ex_mem_o)
    );

endmodule

// File: tests/tb_decode_execute.sv
`timescale 1ns/10ps

module tb_decode_execute;

    typedef struct packed {
        logic [31:0]       inst;
        logic [31:0]       pc;
        pipe_pkg::wb_t     wb;
        logic              stall;
        logic              exp_fetch_stall; // sampled before the rising edge
        pipe_pkg::ex_mem_t exp_em;          // sampled after the rising edge
        logic              exp_redirect;
        logic [31:0]       exp_redirect_pc;
    } row_t;

    logic              clk_i = 1'b0;
    logic              reset_i;
    logic [31:0]       inst_i;
    logic [31:0]       pc_i;
    pipe_pkg::wb_t     wb_i;
    logic              mem_stall_i;
    logic              fetch_stall_o;
    logic              redirect_o;
    logic [31:0]       redirect_pc_o;
    pipe_pkg::ex_mem_t ex_mem_o;

    row_t rows[$];

    decode_execute_top dut0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .wb_i          (wb_i),
        .mem_stall_i   (mem_stall_i),
        .fetch_stall_o (fetch_stall_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .ex_mem_o      (ex_mem_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] r_word(int funct7, int rs2, int rs1, int funct3, int rd);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], pipe_pkg::OP_R};
    endfunction

    function automatic logic [31:0] i_word(int imm, int rs1, int funct3, int rd,
                                           logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] s_word(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], pipe_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(int imm, int rs2, int rs1, int funct3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
                pipe_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], pipe_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] u_word(int imm, int rd);
        return {imm[19:0], rd[4:0], pipe_pkg::OP_LUI};
    endfunction

    function automatic pipe_pkg::wb_t wb_beat(int we, int rd, logic [31:0] data);
        pipe_pkg::wb_t w;
        w.we   = we[0];
        w.rd   = rd[4:0];
        w.data = data;
        return w;
    endfunction

    function automatic pipe_pkg::ex_mem_t em_entry(int rw, int mr, int mw, logic [31:0] result,
                                                   logic [31:0] store_data, int rd);
        pipe_pkg::ex_mem_t e;
        e.reg_write  = rw[0];
        e.mem_read   = mr[0];
        e.mem_write  = mw[0];
        e.result     = result;
        e.store_data = store_data;
        e.rd_addr    = rd[4:0];
        return e;
    endfunction

    task automatic add_row(logic [31:0] inst, logic [31:0] pc, pipe_pkg::wb_t wb, int stall,
                           int fs, pipe_pkg::ex_mem_t em, int redir, logic [31:0] rpc);
        row_t r;
        r.inst            = inst;
        r.pc              = pc;
        r.wb              = wb;
        r.stall           = stall[0];
        r.exp_fetch_stall = fs[0];
        r.exp_em          = em;
        r.exp_redirect    = redir[0];
        r.exp_redirect_pc = rpc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        pipe_pkg::wb_t     idle;
        pipe_pkg::ex_mem_t none;
        idle = wb_beat(0, 0, 0);
        none = em_entry(0, 0, 0, 0, 0, 0);
        add_row(0, 0, wb_beat(1, 1, 32'h5), 0, 0, none, 0, 0);      // x1 = 5
        add_row(0, 0, wb_beat(1, 2, 32'h3), 0, 0, none, 0, 0);      // x2 = 3
        add_row(0, 0, wb_beat(1, 4, 32'h100), 0, 0, none, 0, 0);    // x4 = base
        add_row(r_word(0, 2, 1, 0, 3), 'h00c, idle, 0, 0, none, 0, 0);
        add_row(r_word(32, 1, 3, 0, 5), 'h010, idle, 0, 0, em_entry(1, 0, 0, 8, 3, 3), 0, 0);
        add_row(r_word(0, 2, 3, 4, 6), 'h014, idle, 0, 0, em_entry(1, 0, 0, 3, 5, 5), 0, 0);
        // x3 arrives on the writeback port for the xor
        add_row(i_word(99, 1, 0, 0, pipe_pkg::OP_I), 'h018, wb_beat(1, 3, 8), 0, 0,
                em_entry(1, 0, 0, 'hb, 3, 6), 0, 0);
        add_row(r_word(0, 2, 0, 0, 8), 'h01c, wb_beat(1, 5, 3), 0, 0,
                em_entry(1, 0, 0, 'h68, 0, 0), 0, 0);
        add_row(i_word(8, 4, 2, 9, pipe_pkg::OP_LOAD), 'h020, wb_beat(1, 0, 'hffff_ffff), 0, 0,
                em_entry(1, 0, 0, 3, 3, 8), 0, 0);
        // load-use makes the outside present the add twice
        add_row(r_word(0, 1, 9, 0, 10), 'h024, idle, 0, 1, em_entry(1, 1, 0, 'h108, 0, 9), 0, 0);
        add_row(r_word(0, 1, 9, 0, 10), 'h024, idle, 0, 0, none, 0, 0);
        add_row(s_word(12, 10, 4), 'h028, wb_beat(1, 9, 'h1000), 0, 0,
                em_entry(1, 0, 0, 'h1005, 5, 10), 0, 0);
        add_row(u_word('habcde, 11), 'h02c, idle, 0, 0, em_entry(0, 0, 1, 'h10c, 'h1005, 0), 0, 0);
        add_row(b_word(16, 5, 2, 0), 'h200, idle, 0, 0,
                em_entry(1, 0, 0, 'habcde000, 0, 11), 1, 'h210);
        add_row(i_word(1, 1, 0, 12, pipe_pkg::OP_I), 'h204, idle, 0, 0,
                em_entry(0, 0, 0, 6, 3, 0), 0, 0);
        add_row(j_word('h40, 13), 'h210, idle, 0, 0, none, 1, 'h250);
        add_row(r_word(0, 1, 1, 0, 14), 'h214, idle, 0, 0, em_entry(1, 0, 0, 'h214, 0, 13), 0, 0);
        add_row(b_word(8, 5, 2, 1), 'h250, idle, 0, 0, none, 0, 0);    // bne with equal operands
        add_row(i_word(5, 4, 0, 15, pipe_pkg::OP_JALR), 'h254, idle, 0, 0,
                em_entry(0, 0, 0, 6, 3, 0), 1, 'h104);
        add_row(i_word(7, 1, 0, 16, pipe_pkg::OP_I), 'h258, idle, 0, 0,
                em_entry(1, 0, 0, 'h258, 0, 15), 0, 0);
        add_row(i_word(16, 1, 0, 17, pipe_pkg::OP_I), 'h104, idle, 0, 0, none, 0, 0);
        add_row(r_word(0, 1, 17, 0, 18), 'h108, idle, 0, 0, em_entry(1, 0, 0, 'h15, 0, 17), 0, 0);
        // memory side stalls for three cycles
        for (int n = 0; n < 3; n++) begin
            add_row(r_word(32, 2, 18, 0, 19), 'h10c, idle, 1, 0,
                    em_entry(1, 0, 0, 'h15, 0, 17), 0, 0);
        end
        add_row(r_word(32, 2, 18, 0, 19), 'h10c, idle, 0, 0,
                em_entry(1, 0, 0, 'h1a, 5, 18), 0, 0);
        add_row(0, 0, idle, 0, 0, em_entry(1, 0, 0, 'h17, 3, 19), 0, 0);
        add_row(0, 0, idle, 0, 0, none, 0, 0);
    endtask

    task automatic compare_field(int row, string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: row %0d, %s is %h, expected %h",
                     $time, row, name, got, exp);
            $display("Regression failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic verify_ex_mem(int row, pipe_pkg::ex_mem_t exp);
        compare_field(row, "ex_mem_o.reg_write", 32'(ex_mem_o.reg_write), 32'(exp.reg_write));
        compare_field(row, "ex_mem_o.mem_read", 32'(ex_mem_o.mem_read), 32'(exp.mem_read));
        compare_field(row, "ex_mem_o.mem_write", 32'(ex_mem_o.mem_write), 32'(exp.mem_write));
        compare_field(row, "ex_mem_o.result", ex_mem_o.result, exp.result);
        compare_field(row, "ex_mem_o.store_data", ex_mem_o.store_data, exp.store_data);
        compare_field(row, "ex_mem_o.rd_addr", 32'(ex_mem_o.rd_addr), 32'(exp.rd_addr));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < 20) begin
            @(posedge clk_i);
            cycles++;
        end
        if (reset_i !== 1'b0) begin
            $display("Regression failed");
            $fatal(1, "reset was still high after 20 cycles");
        end
    endtask

    // random contents in every register including x0
    task automatic preload_registers();
        pipe_pkg::wb_t w;
        for (int r = 0; r < 32; r++) begin
            @(negedge clk_i);
            w.we   = 1'b1;
            w.rd   = r[4:0];
            w.data = $urandom;
            wb_i   = w;
        end
    endtask

    task automatic run_table();
        row_t r;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk_i);
            r           = rows[i];
            inst_i      = r.inst;
            pc_i        = r.pc;
            wb_i        = r.wb;
            mem_stall_i = r.stall;
            #2;
            compare_field(i, "fetch_stall_o", 32'(fetch_stall_o), 32'(r.exp_fetch_stall));
            @(posedge clk_i);
            #1;
            verify_ex_mem(i, r.exp_em);
            compare_field(i, "redirect_o", 32'(redirect_o), 32'(r.exp_redirect));
            if (r.exp_redirect) begin
                compare_field(i, "redirect_pc_o", redirect_pc_o, r.exp_redirect_pc);
            end
        end
    endtask

    initial begin
        reset_i = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
    end

    initial begin
        #5000;
        $display("Regression failed");
        $fatal(1, "simulation did not finish within 5000 ns");
    end

    initial begin
        void'($urandom(32'h0a73_87c1));
        inst_i      = '0;
        pc_i        = '0;
        wb_i        = '0;
        mem_stall_i = 1'b0;
        build_table();
        wait_reset_release();
        #1;
        verify_ex_mem(-1, em_entry(0, 0, 0, 0, 0, 0));
        compare_field(-1, "redirect_o", 32'(redirect_o), 0);
        compare_field(-1, "fetch_stall_o", 32'(fetch_stall_o), 0);
        preload_registers();
        run_table();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: verilog.f
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/stage_reg.sv
verilog/exec_stage.sv
verilog/decode_execute_top.sv
tests/tb_decode_execute.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_decode_execute \
    -o tb_decode_execute
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/tb_decode_execute
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0
